// File: Bender.yml
package:
  name: header_deparser

export_include_dirs:
  - .

sources:
  - deparser_pkg.sv
  - header_patch.sv
  - header_deparser.sv
  - ctrl_table_writer.sv
  - table_arbiter.sv
  - action_table.sv
  - deparser_top.sv
  - target: test
    files:
      - deparser_assertions.sv
      - deparser_tb.sv

// File: action_table.sv
`timescale 1ns/1ps
`include "deparser_config.svh"

module action_table (
	input  logic                      clk,
	input  logic                      aresetn,
	input  logic                      cyc,
	input  logic                      stb,
	input  logic                      we,
	input  deparser_pkg::entry_idx_t  adr,
	input  deparser_pkg::entry_t      dat_w,
	output deparser_pkg::entry_t      dat_r,
	output logic                      ack
);
	import deparser_pkg::*;

	entry_t mem [`DP_ENTRIES];
	logic   req;

	// the ack cycle itself is not a new request
	assign req = cyc && stb && !ack;

	// all entries start out invalid
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			for (int i = 0; i < `DP_ENTRIES; i++)
				mem[i] <= '0;
			ack <= 1'b0;
		end else begin
			ack <= req;
			if (req && we)
				mem[adr] <= dat_w;
		end
	end

	always_ff @(posedge clk) begin
		if (req && !we)
			dat_r <= mem[adr];
	end

endmodule

// File: ctrl_table_writer.sv
`timescale 1ns/1ps
`include "deparser_config.svh"

module ctrl_table_writer (
	input  logic                      clk,
	input  logic                      aresetn,
	input  logic [`DP_DATA_W-1:0]     c_tdata,
	input  logic                      c_tvalid,
	input  logic                      c_tlast,
	output logic                      c_tready,
	output logic                      cyc,
	output logic                      stb,
	output logic                      we,
	output deparser_pkg::entry_idx_t  adr,
	output deparser_pkg::entry_t      dat_w,
	input  logic                      ack
);
	import deparser_pkg::*;

	typedef enum logic [1:0] {
		W_IDLE,
		W_SKIP,
		W_DATA,
		W_BUSY
	} wr_state_t;

	wr_state_t  state;
	entry_idx_t idx;
	logic       last_r;
	logic       hdr_match;
	logic       beat;

	assign hdr_match = (c_tdata[`DP_FLAG_LSB +: `DP_FLAG_W] == `DP_CTRL_FLAG) &&
		(c_tdata[`DP_MODID_LSB +: `DP_MODID_W] == `DP_MODULE_ID);

	// no new beat while a table write is outstanding
	assign c_tready = (state != W_BUSY);
	assign beat = c_tvalid && c_tready;
	assign we = stb;
	assign adr = idx;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state <= W_IDLE;
			cyc <= 1'b0;
			stb <= 1'b0;
			idx <= '0;
			last_r <= 1'b0;
		end else begin
			case (state)
				W_IDLE: begin
					if (beat && !c_tlast) begin
						if (hdr_match) begin
							idx <= c_tdata[`DP_START_LSB +: $bits(entry_idx_t)];
							state <= W_DATA;
						end else begin
							state <= W_SKIP;
						end
					end
				end
				// drop a foreign stream until its end
				W_SKIP: begin
					if (beat && c_tlast)
						state <= W_IDLE;
				end
				W_DATA: begin
					if (beat) begin
						cyc <= 1'b1;
						stb <= 1'b1;
						last_r <= c_tlast;
						state <= W_BUSY;
					end
				end
				W_BUSY: begin
					if (ack) begin
						cyc <= 1'b0;
						stb <= 1'b0;
						idx <= idx + 1'b1;
						state <= last_r ? W_IDLE : W_DATA;
					end
				end
				default: state <= W_IDLE;
			endcase
		end
	end

	// entry taken from the low bits of the beat
	always_ff @(posedge clk) begin
		if (state == W_DATA && beat)
			dat_w <= c_tdata[$bits(entry_t)-1:0];
	end

endmodule

// File: deparser_assertions.sv
`timescale 1ns/1ps
`include "deparser_config.svh"

module deparser_assertions (
	input logic                  clk,
	input logic                  aresetn,
	input logic                  pkt_empty,
	input logic                  pkt_rd_en,
	input logic                  phv_empty,
	input logic                  phv_rd_en,
	input logic [`DP_DATA_W-1:0] out_tdata,
	input logic [`DP_KEEP_W-1:0] out_tkeep,
	input logic                  out_tlast,
	input logic                  out_tvalid,
	input logic                  out_tready,
	input logic                  c_tready
);

	int unsigned errors = 0;

	// idle outputs while in reset
	reset_state: assert property (@(posedge clk)
		!aresetn |-> (!out_tvalid && !pkt_rd_en && !phv_rd_en && c_tready))
	else begin
		$error("outputs not in their reset state");
		errors++;
	end

	// stalled beat holds still
	out_stable: assert property (@(posedge clk) disable iff (!aresetn)
		out_tvalid && !out_tready |=>
			out_tvalid && $stable(out_tdata) && $stable(out_tkeep) && $stable(out_tlast))
	else begin
		$error("output beat changed under back-pressure");
		errors++;
	end

	pkt_pop_ok: assert property (@(posedge clk) disable iff (!aresetn)
		pkt_rd_en |-> !pkt_empty)
	else begin
		$error("packet fifo popped while empty");
		errors++;
	end

	phv_pop_ok: assert property (@(posedge clk) disable iff (!aresetn)
		phv_rd_en |-> !phv_empty)
	else begin
		$error("phv fifo popped while empty");
		errors++;
	end

endmodule

bind deparser_top deparser_assertions deparser_assertions_i (.*);

// File: deparser_config.svh
`ifndef DEPARSER_CONFIG_SVH
`define DEPARSER_CONFIG_SVH

// packet and control beat width
`define DP_DATA_W 128
`define DP_KEEP_W 16

// header region patched per packet over two beats
`define DP_HDR_BYTES 32

// action table
`define DP_ENTRIES 16
`define DP_ACTIONS 4

// containers of each size in the phv
`define DP_CONTAINERS 4

// control stream matching
`define DP_CTRL_FLAG 16'hf2f1
`define DP_MODULE_ID 3'd5

// control header field positions
`define DP_FLAG_LSB 112
`define DP_FLAG_W 16
`define DP_MODID_LSB 104
`define DP_MODID_W 3
`define DP_START_LSB 96

`endif

// File: deparser_pkg.sv
`include "deparser_config.svh"

package deparser_pkg;

	// action table address
	typedef logic [$clog2(`DP_ENTRIES)-1:0] entry_idx_t;

	// container size selected by an action
	typedef enum logic [1:0] {
		KIND_NONE = 2'b00,
		KIND_2B   = 2'b01,
		KIND_4B   = 2'b10,
		KIND_6B   = 2'b11
	} kind_t;

	// one action with valid in bit 0
	typedef struct packed {
		logic [5:0] rsvd;
		logic [4:0] offset;
		logic [1:0] idx;
		kind_t      kind;
		logic       valid;
	} action_t;

	// action j sits at bits 16j and up
	typedef action_t [`DP_ACTIONS-1:0] entry_t;

	// entry index on top, then 6, 4 and 2 byte containers
	typedef struct packed {
		entry_idx_t                        idx;
		logic [`DP_CONTAINERS-1:0][47:0] c6;
		logic [`DP_CONTAINERS-1:0][31:0] c4;
		logic [`DP_CONTAINERS-1:0][15:0] c2;
	} phv_t;

	// header byte n at bits 8n+7..8n
	typedef logic [`DP_HDR_BYTES-1:0][7:0] hdr_t;

endpackage

// File: deparser_tb.sv
`timescale 1ns/1ps
`include "deparser_config.svh"

module deparser_tb;

	localparam logic [31:0] SEED = 32'h8f01_e321;

	logic                  clk;
	logic                  aresetn;
	logic [`DP_DATA_W-1:0] pkt_tdata;
	logic [`DP_KEEP_W-1:0] pkt_tkeep;
	logic                  pkt_tlast;
	logic                  pkt_empty;
	logic                  pkt_rd_en;
	logic [387:0]          phv_data;
	logic                  phv_empty;
	logic                  phv_rd_en;
	logic [`DP_DATA_W-1:0] out_tdata;
	logic [`DP_KEEP_W-1:0] out_tkeep;
	logic                  out_tlast;
	logic                  out_tvalid;
	logic                  out_tready;
	logic [`DP_DATA_W-1:0] c_tdata;
	logic                  c_tvalid;
	logic                  c_tlast;
	logic                  c_tready;

	// fifo contents and expected output beats
	logic [127:0] pd_q[$];
	logic [15:0]  pk_q[$];
	logic         pl_q[$];
	logic [387:0] phv_q[$];
	logic [127:0] ed_q[$];
	logic [15:0]  ek_q[$];
	logic         el_q[$];

	logic [63:0] model_tab [16];
	logic [31:0] stim_lfsr;
	logic [31:0] ready_lfsr;
	logic        bp_on;
	int          cycles;
	int          sent;

	deparser_top deparser_top_i (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [127:0] rand_bits(int n);
		logic [127:0] r;
		r = '0;
		for (int b = 0; b < n; b++) begin
			stim_lfsr = lfsr_next(stim_lfsr);
			r[b] = stim_lfsr[0];
		end
		return r;
	endfunction

	// container msb lands at the offset and later actions overwrite
	function automatic logic [255:0] model_patch(logic [255:0] h, logic [387:0] p,
			logic [63:0] e);
		logic [15:0] a;
		logic [47:0] c;
		int          len;
		int          pos;
		for (int j = 0; j < 4; j++) begin
			a = e[16*j +: 16];
			len = a[0] ? 2 * int'(a[2:1]) : 0;
			case (a[2:1])
				2'b01: c = {32'b0, p[16*int'(a[4:3]) +: 16]};
				2'b10: c = {16'b0, p[64 + 32*int'(a[4:3]) +: 32]};
				default: c = p[192 + 48*int'(a[4:3]) +: 48];
			endcase
			for (int b = 0; b < len; b++) begin
				pos = int'(a[9:5]) + b;
				if (pos < 32)
					h[8*pos +: 8] = c[8*(len-1-b) +: 8];
			end
		end
		return h;
	endfunction

	task automatic stop_run(string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic send_ctrl(logic [15:0] flag, logic [2:0] modid, logic [3:0] start, int n);
		logic [127:0] beat;
		logic         hit;
		hit = (flag == `DP_CTRL_FLAG) && (modid == `DP_MODULE_ID);
		for (int k = 0; k <= n; k++) begin
			beat = rand_bits(128);
			if (k == 0) begin
				beat[127:96] = {flag, 5'b0, modid, 4'b0, start};
			end else begin
				// most actions valid
				beat[0] = 1'b1;
				beat[16] = 1'b1;
				beat[32] = 1'b1;
				if (hit)
					model_tab[4'(start + k - 1)] = beat[63:0];
			end
			c_tdata <= beat;
			c_tvalid <= 1'b1;
			c_tlast <= (k == n);
			sent++;
			do @(posedge clk); while (!c_tready);
		end
		c_tvalid <= 1'b0;
		c_tlast <= 1'b0;
	endtask

	task automatic send_pkt(logic [3:0] idx, int nbeats);
		logic [387:0] p;
		logic [127:0] d [6];
		logic [15:0]  k;
		logic [255:0] h;
		p = {idx, rand_bits(128), rand_bits(128), rand_bits(128)};
		for (int b = 0; b < nbeats; b++)
			d[b] = rand_bits(128);
		h = {(nbeats > 1) ? d[1] : 128'b0, d[0]};
		h = model_patch(h, p, model_tab[idx]);
		@(negedge clk);
		phv_q.push_back(p);
		for (int b = 0; b < nbeats; b++) begin
			k = (b == nbeats - 1) ? 16'(rand_bits(16) | 128'd1) : 16'hffff;
			pd_q.push_back(d[b]);
			pk_q.push_back(k);
			pl_q.push_back(b == nbeats - 1);
			ed_q.push_back(b == 0 ? h[127:0] : (b == 1 ? h[255:128] : d[b]));
			ek_q.push_back(k);
			el_q.push_back(b == nbeats - 1);
		end
		sent++;
		@(posedge clk);
	endtask

	task automatic send_random_pkts(int n, int idx_base, int idx_span);
		for (int i = 0; i < n; i++)
			send_pkt(4'(idx_base + int'(rand_bits(8)) % idx_span), 1 + int'(rand_bits(8)) % 6);
	endtask

	task automatic wait_drain();
		while (ed_q.size() != 0)
			@(posedge clk);
	endtask

	// show-ahead fifos
	always @(posedge clk) begin
		if (pkt_rd_en) begin
			void'(pd_q.pop_front());
			void'(pk_q.pop_front());
			void'(pl_q.pop_front());
		end
		if (phv_rd_en)
			void'(phv_q.pop_front());
		pkt_empty <= (pd_q.size() == 0);
		pkt_tdata <= (pd_q.size() != 0) ? pd_q[0] : '0;
		pkt_tkeep <= (pk_q.size() != 0) ? pk_q[0] : '0;
		pkt_tlast <= (pl_q.size() != 0) ? pl_q[0] : 1'b0;
		phv_empty <= (phv_q.size() == 0);
		phv_data <= (phv_q.size() != 0) ? phv_q[0] : '0;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > 400 * sent + 200)
			stop_run("timeout: the DUT stopped making progress");
		if (deparser_top_i.deparser_assertions_i.errors != 0)
			stop_run("a protocol assertion on the DUT ports failed");
		if (aresetn && out_tvalid && out_tready) begin
			assert (ed_q.size() != 0)
			else stop_run("the DUT sent a beat when no packet was expected");
			assert (out_tdata == ed_q[0] && out_tkeep == ek_q[0] && out_tlast == el_q[0])
			else stop_run($sformatf("error at %0d ns: beat %h %h %b, expected %h %h %b",
				$time, out_tdata, out_tkeep, out_tlast, ed_q[0], ek_q[0], el_q[0]));
			void'(ed_q.pop_front());
			void'(ek_q.pop_front());
			void'(el_q.pop_front());
		end
		ready_lfsr = lfsr_next(ready_lfsr);
		out_tready <= !bp_on || ready_lfsr[0];
	end

	initial begin
		clk = 1'b0;
		aresetn = 1'b0;
		pkt_tdata = '0;
		pkt_tkeep = '0;
		pkt_tlast = 1'b0;
		pkt_empty = 1'b1;
		phv_data = '0;
		phv_empty = 1'b1;
		out_tready = 1'b1;
		c_tdata = '0;
		c_tvalid = 1'b0;
		c_tlast = 1'b0;
		bp_on = 1'b0;
		stim_lfsr = SEED;
		ready_lfsr = SEED;
		cycles = 0;
		sent = 0;
		for (int i = 0; i < 16; i++)
			model_tab[i] = '0;
		repeat (8) @(posedge clk);
		aresetn <= 1'b1;
		@(posedge clk);

		// empty table leaves the header alone
		send_pkt(4'd3, 3);
		wait_drain();
		send_ctrl(`DP_CTRL_FLAG, `DP_MODULE_ID, 4'd0, 16);
		send_random_pkts(12, 0, 16);

		// foreign streams must not touch the table
		send_ctrl(16'h1234, `DP_MODULE_ID, 4'd0, 8);
		send_ctrl(`DP_CTRL_FLAG, 3'd2, 4'd8, 8);
		send_random_pkts(8, 0, 16);

		bp_on <= 1'b1;
		send_random_pkts(20, 0, 16);
		wait_drain();

		// rewrite entries 12..15 while packets use the others
		fork
			send_ctrl(`DP_CTRL_FLAG, `DP_MODULE_ID, 4'd12, 4);
			send_random_pkts(10, 0, 12);
		join
		send_random_pkts(6, 12, 4);
		wait_drain();
		@(posedge clk);

		if (deparser_top_i.deparser_assertions_i.errors != 0) begin
			stop_run("a protocol assertion on the DUT ports failed");
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

// File: deparser_top.f
+incdir+.
deparser_pkg.sv
header_patch.sv
header_deparser.sv
ctrl_table_writer.sv
table_arbiter.sv
action_table.sv
deparser_top.sv
deparser_assertions.sv
deparser_tb.sv

// File: deparser_top.sv
`timescale 1ns/1ps
`include "deparser_config.svh"

module deparser_top (
	input  logic                    clk,
	input  logic                    aresetn,

	input  logic [`DP_DATA_W-1:0]   pkt_tdata,
	input  logic [`DP_KEEP_W-1:0]   pkt_tkeep,
	input  logic                    pkt_tlast,
	input  logic                    pkt_empty,
	output logic                    pkt_rd_en,

	input  deparser_pkg::phv_t      phv_data,
	input  logic                    phv_empty,
	output logic                    phv_rd_en,

	output logic [`DP_DATA_W-1:0]   out_tdata,
	output logic [`DP_KEEP_W-1:0]   out_tkeep,
	output logic                    out_tlast,
	output logic                    out_tvalid,
	input  logic                    out_tready,

	input  logic [`DP_DATA_W-1:0]   c_tdata,
	input  logic                    c_tvalid,
	input  logic                    c_tlast,
	output logic                    c_tready
);
	import deparser_pkg::*;

	// writer side of the arbiter
	logic       wr_cyc;
	logic       wr_stb;
	logic       wr_we;
	entry_idx_t wr_adr;
	entry_t     wr_dat_w;
	logic       wr_ack;

	// deparser side
	logic       rd_cyc;
	logic       rd_stb;
	entry_idx_t rd_adr;
	entry_t     rd_dat_r;
	logic       rd_ack;

	// table side
	logic       tb_cyc;
	logic       tb_stb;
	logic       tb_we;
	entry_idx_t tb_adr;
	entry_t     tb_dat_w;
	entry_t     tb_dat_r;
	logic       tb_ack;

	ctrl_table_writer ctrl_table_writer_i (
		.clk      (clk),
		.aresetn  (aresetn),
		.c_tdata  (c_tdata),
		.c_tvalid (c_tvalid),
		.c_tlast  (c_tlast),
		.c_tready (c_tready),
		.cyc      (wr_cyc),
		.stb      (wr_stb),
		.we       (wr_we),
		.adr      (wr_adr),
		.dat_w    (wr_dat_w),
		.ack      (wr_ack)
	);

	header_deparser header_deparser_i (
		.clk        (clk),
		.aresetn    (aresetn),
		.pkt_tdata  (pkt_tdata),
		.pkt_tkeep  (pkt_tkeep),
		.pkt_tlast  (pkt_tlast),
		.pkt_empty  (pkt_empty),
		.pkt_rd_en  (pkt_rd_en),
		.phv_data   (phv_data),
		.phv_empty  (phv_empty),
		.phv_rd_en  (phv_rd_en),
		.out_tdata  (out_tdata),
		.out_tkeep  (out_tkeep),
		.out_tlast  (out_tlast),
		.out_tvalid (out_tvalid),
		.out_tready (out_tready),
		.wb_cyc     (rd_cyc),
		.wb_stb     (rd_stb),
		.wb_adr     (rd_adr),
		.wb_dat_r   (rd_dat_r),
		.wb_ack     (rd_ack)
	);

	table_arbiter table_arbiter_i (
		.clk      (clk),
		.aresetn  (aresetn),
		.m0_cyc   (wr_cyc),
		.m0_stb   (wr_stb),
		.m0_we    (wr_we),
		.m0_adr   (wr_adr),
		.m0_dat_w (wr_dat_w),
		.m0_ack   (wr_ack),
		.m1_cyc   (rd_cyc),
		.m1_stb   (rd_stb),
		.m1_adr   (rd_adr),
		.m1_dat_r (rd_dat_r),
		.m1_ack   (rd_ack),
		.s_cyc    (tb_cyc),
		.s_stb    (tb_stb),
		.s_we     (tb_we),
		.s_adr    (tb_adr),
		.s_dat_w  (tb_dat_w),
		.s_dat_r  (tb_dat_r),
		.s_ack    (tb_ack)
	);

	action_table action_table_i (
		.clk     (clk),
		.aresetn (aresetn),
		.cyc     (tb_cyc),
		.stb     (tb_stb),
		.we      (tb_we),
		.adr     (tb_adr),
		.dat_w   (tb_dat_w),
		.dat_r   (tb_dat_r),
		.ack     (tb_ack)
	);

endmodule

// File: header_deparser.sv
`timescale 1ns/1ps
`include "deparser_config.svh"

module header_deparser (
	input  logic                      clk,
	input  logic                      aresetn,

	input  logic [`DP_DATA_W-1:0]     pkt_tdata,
	input  logic [`DP_KEEP_W-1:0]     pkt_tkeep,
	input  logic                      pkt_tlast,
	input  logic                      pkt_empty,
	output logic                      pkt_rd_en,

	input  deparser_pkg::phv_t        phv_data,
	input  logic                      phv_empty,
	output logic                      phv_rd_en,

	output logic [`DP_DATA_W-1:0]     out_tdata,
	output logic [`DP_KEEP_W-1:0]     out_tkeep,
	output logic                      out_tlast,
	output logic                      out_tvalid,
	input  logic                      out_tready,

	output logic                      wb_cyc,
	output logic                      wb_stb,
	output deparser_pkg::entry_idx_t  wb_adr,
	input  deparser_pkg::entry_t      wb_dat_r,
	input  logic                      wb_ack
);
	import deparser_pkg::*;

	typedef enum logic [2:0] {
		D_IDLE,
		D_BEAT0,
		D_BEAT1,
		D_TABLE,
		D_PATCH,
		D_SEND0,
		D_SEND1,
		D_PASS
	} dp_state_t;

	dp_state_t                   state;
	hdr_t                        hdr_buf;
	hdr_t                        hdr_patched;
	logic [1:0][`DP_KEEP_W-1:0] keep_buf;
	logic [1:0]                  last_buf;
	entry_t                      entry_r;

	header_patch header_patch_i (
		.hdr_in  (hdr_buf),
		.phv     (phv_data),
		.entry   (entry_r),
		.hdr_out (hdr_patched)
	);

	// phv stays at the fifo head until the patch cycle
	assign wb_cyc = (state == D_TABLE);
	assign wb_stb = (state == D_TABLE);
	assign wb_adr = phv_data.idx;

	always_comb begin
		pkt_rd_en = 1'b0;
		phv_rd_en = 1'b0;
		out_tvalid = 1'b0;
		out_tdata = pkt_tdata;
		out_tkeep = pkt_tkeep;
		out_tlast = pkt_tlast;
		case (state)
			D_BEAT0: pkt_rd_en = 1'b1;
			D_BEAT1: pkt_rd_en = !pkt_empty;
			D_PATCH: phv_rd_en = 1'b1;
			D_SEND0: begin
				out_tvalid = 1'b1;
				out_tdata = hdr_buf[`DP_KEEP_W-1:0];
				out_tkeep = keep_buf[0];
				out_tlast = last_buf[0];
			end
			D_SEND1: begin
				out_tvalid = 1'b1;
				out_tdata = hdr_buf[`DP_HDR_BYTES-1:`DP_KEEP_W];
				out_tkeep = keep_buf[1];
				out_tlast = last_buf[1];
			end
			// rest of the packet straight from the fifo head
			D_PASS: begin
				out_tvalid = !pkt_empty;
				pkt_rd_en = !pkt_empty && out_tready;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state <= D_IDLE;
		end else begin
			case (state)
				D_IDLE: begin
					if (!pkt_empty && !phv_empty)
						state <= D_BEAT0;
				end
				D_BEAT0: state <= pkt_tlast ? D_TABLE : D_BEAT1;
				D_BEAT1: begin
					if (!pkt_empty)
						state <= D_TABLE;
				end
				D_TABLE: begin
					if (wb_ack)
						state <= D_PATCH;
				end
				D_PATCH: state <= D_SEND0;
				D_SEND0: begin
					if (out_tready)
						state <= last_buf[0] ? D_IDLE : D_SEND1;
				end
				D_SEND1: begin
					if (out_tready)
						state <= last_buf[1] ? D_IDLE : D_PASS;
				end
				D_PASS: begin
					if (!pkt_empty && out_tready && pkt_tlast)
						state <= D_IDLE;
				end
				default: state <= D_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == D_BEAT0) begin
			hdr_buf[`DP_KEEP_W-1:0] <= pkt_tdata;
			keep_buf[0] <= pkt_tkeep;
			last_buf[0] <= pkt_tlast;
		end
		if (state == D_BEAT1 && !pkt_empty) begin
			hdr_buf[`DP_HDR_BYTES-1:`DP_KEEP_W] <= pkt_tdata;
			keep_buf[1] <= pkt_tkeep;
			last_buf[1] <= pkt_tlast;
		end
		if (state == D_TABLE && wb_ack)
			entry_r <= wb_dat_r;
		if (state == D_PATCH)
			hdr_buf <= hdr_patched;
	end

endmodule

// File: header_patch.sv
`timescale 1ns/1ps
`include "deparser_config.svh"

module header_patch (
	input  deparser_pkg::hdr_t    hdr_in,
	input  deparser_pkg::phv_t    phv,
	input  deparser_pkg::entry_t  entry,
	output deparser_pkg::hdr_t    hdr_out
);
	import deparser_pkg::*;

	// container written msb first from the action offset
	function automatic hdr_t apply_action(hdr_t h, action_t a, phv_t p);
		logic [47:0] cont;
		int          len;
		int          pos;
		cont = '0;
		len = 0;
		case (a.kind)
			KIND_2B: begin
				cont[15:0] = p.c2[a.idx];
				len = 2;
			end
			KIND_4B: begin
				cont[31:0] = p.c4[a.idx];
				len = 4;
			end
			KIND_6B: begin
				cont = p.c6[a.idx];
				len = 6;
			end
			default: len = 0;
		endcase
		if (!a.valid)
			len = 0;
		for (int b = 0; b < 6; b++) begin
			pos = int'(a.offset) + b;
			// bytes past the header end are dropped
			if (b < len && pos < `DP_HDR_BYTES)
				h[pos] = cont[8*(len-1-b) +: 8];
		end
		return h;
	endfunction

	// later actions win on overlap
	always_comb begin
		hdr_out = hdr_in;
		for (int j = 0; j < `DP_ACTIONS; j++)
			hdr_out = apply_action(hdr_out, entry[j], phv);
	end

endmodule

// File: table_arbiter.sv
`timescale 1ns/1ps

module table_arbiter (
	input  logic                      clk,
	input  logic                      aresetn,

	input  logic                      m0_cyc,
	input  logic                      m0_stb,
	input  logic                      m0_we,
	input  deparser_pkg::entry_idx_t  m0_adr,
	input  deparser_pkg::entry_t      m0_dat_w,
	output logic                      m0_ack,

	input  logic                      m1_cyc,
	input  logic                      m1_stb,
	input  deparser_pkg::entry_idx_t  m1_adr,
	output deparser_pkg::entry_t      m1_dat_r,
	output logic                      m1_ack,

	output logic                      s_cyc,
	output logic                      s_stb,
	output logic                      s_we,
	output deparser_pkg::entry_idx_t  s_adr,
	output deparser_pkg::entry_t      s_dat_w,
	input  deparser_pkg::entry_t      s_dat_r,
	input  logic                      s_ack
);

	// 0 is the writer, 1 the deparser
	logic grant;

	// hand over only once the owner has dropped cyc
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			grant <= 1'b0;
		end else if (!grant && !m0_cyc && m1_cyc) begin
			grant <= 1'b1;
		end else if (grant && !m1_cyc && m0_cyc) begin
			grant <= 1'b0;
		end
	end

	assign s_cyc = grant ? m1_cyc : m0_cyc;
	assign s_stb = grant ? m1_stb : m0_stb;
	assign s_adr = grant ? m1_adr : m0_adr;

	// deparser only reads
	assign s_we = grant ? 1'b0 : m0_we;
	assign s_dat_w = m0_dat_w;
	assign m1_dat_r = s_dat_r;

	assign m0_ack = s_ack && !grant;
	assign m1_ack = s_ack && grant;

endmodule
